//--- list.f
+incdir+.
iq_types_pkg.sv
smi_types_pkg.sv
lvds_rx.sv
sample_fifo.sv
smi_rx_reader.sv
rx_modem_top.sv
tb_rx_props.sv
tb_rx_checker.sv
tb_rx_modem.sv

//--- run.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module tb_rx_modem -f list.f -o tb_rx_modem \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_rx_modem +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "TB PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- tb_rx_modem.sv
`timescale 1ns/100ps
`include "cariboulite_defs.svh"

module tb_rx_modem
  import iq_types_pkg::*, smi_types_pkg::*;
();

  // One stimulus row, lane 0 is 09 and lane 1 is 24
  typedef struct packed {
    logic       lane;
    logic       sel;
    iq_sample_t sample;
    int         fill;
    logic       drain;
  } row_t;

  logic       glob_clock;
  logic       rst_b;
  ddr_pair_t  pair_09;
  ddr_pair_t  pair_24;
  logic       smi_a3;
  logic       smi_soe_se;
  smi_byte_t  smi_data;
  logic       smi_read_req;
  logic       rx_overflow;
  // Events for the checker
  logic       frame_stb;
  logic       frame_sel;
  iq_sample_t frame_sample;
  logic       row_stb;
  int         row_idx;
  logic       row_drain;
  logic       report;
  int         err_cnt;

  row_t        rows_q[$];
  logic [15:0] lfsr;
  int          cycle_cnt = 0;
  int          cycle_limit;

  rx_modem_top i_dut (
    .i_glob_clock   (glob_clock),
    .i_rst_b        (rst_b),
    .i_iq_rx_09_pair(pair_09),
    .i_iq_rx_24_pair(pair_24),
    .i_smi_a3       (smi_a3),
    .i_smi_soe_se   (smi_soe_se),
    .o_smi_data     (smi_data),
    .o_smi_read_req (smi_read_req),
    .o_rx_overflow  (rx_overflow)
  );

  bind rx_modem_top tb_rx_props u_props (
    .i_glob_clock  (i_glob_clock),
    .i_rst_b       (i_rst_b),
    .i_smi_soe_se  (i_smi_soe_se),
    .i_smi_data    (o_smi_data),
    .i_smi_read_req(o_smi_read_req),
    .i_rx_overflow (o_rx_overflow)
  );

  tb_rx_checker u_check (
    .i_glob_clock  (glob_clock),
    .i_rst_b       (rst_b),
    .i_smi_soe_se  (smi_soe_se),
    .i_smi_data    (smi_data),
    .i_smi_read_req(smi_read_req),
    .i_rx_overflow (rx_overflow),
    .i_frame_stb   (frame_stb),
    .i_frame_sel   (frame_sel),
    .i_frame_sample(frame_sample),
    .i_row_stb     (row_stb),
    .i_row_idx     (row_idx),
    .i_row_drain   (row_drain),
    .i_report      (report),
    .o_err_cnt     (err_cnt)
  );

  // 25 MHz
  initial begin
    glob_clock = 1'b0;
    forever #20 glob_clock = ~glob_clock;
  end

  // Hard stop if the host or a lane stalls
  always @(posedge glob_clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: still running after %0d cycles", cycle_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  // ==========================================================================
  // Stimulus helpers
  // ==========================================================================
  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Two bits per filler pair, one step each
  task automatic take_filler(output ddr_pair_t p);
    p[1] = lfsr[0];
    lfsr = lfsr_step(lfsr);
    p[0] = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  // Logical pair in, pin level out, other lane idles at zero
  task automatic drive_pair(input logic lane, input ddr_pair_t p);
    @(negedge glob_clock);
    if (lane) begin
      pair_24 = ~p;
      pair_09 = '0;
    end else begin
      pair_09 = p;
      pair_24 = '0;
    end
  endtask

  task automatic take_byte();
    @(negedge glob_clock);
    while (!smi_read_req) @(negedge glob_clock);
    // soe high for 2 cycles, then low for 1
    smi_soe_se = 1'b1;
    repeat (2) @(negedge glob_clock);
    smi_soe_se = 1'b0;
  endtask

  task automatic drain_host();
    int idle;
    idle = 0;
    // FIFO counts as empty after 8 quiet cycles
    while (idle < 8) begin
      @(negedge glob_clock);
      if (smi_read_req) begin
        repeat (`SMI_BYTES) take_byte();
        idle = 0;
      end else begin
        idle++;
      end
    end
  endtask

  task automatic add_row(input logic lane, input logic sel, input iq_sample_t sample,
                         input int fill, input logic drain);
    row_t r;
    r.lane   = lane;
    r.sel    = sel;
    r.sample = sample;
    r.fill   = fill;
    r.drain  = drain;
    rows_q.push_back(r);
  endtask

  // Top pair of every sample is the 2'b10 marker
  task automatic build_table();
    add_row(1'b0, 1'b0, 32'hA5C3_1E7F, 5, 1'b1);
    add_row(1'b1, 1'b1, 32'h9B24_6D80, 3, 1'b1);
    add_row(1'b0, 1'b0, 32'h8001_FFFE, 12, 1'b1);
    // Unselected lanes, nothing may come out
    add_row(1'b1, 1'b0, 32'hB0B0_0B0B, 4, 1'b1);
    add_row(1'b0, 1'b1, 32'h8888_1111, 2, 1'b1);
    add_row(1'b1, 1'b1, 32'hBEEF_0042, 0, 1'b1);
    // Back-pressure, drained only after the last frame
    for (int n = 0; n < 18; n++) begin
      add_row(1'b0, 1'b0, 32'h8000_0000 + 32'h0101_0101 * n, 2, n == 17);
    end
  endtask

  task automatic run_row(input int idx, input row_t r);
    ddr_pair_t p;
    @(negedge glob_clock);
    smi_a3 = r.sel;
    for (int i = 0; i < r.fill; i++) begin
      take_filler(p);
      // Filler must never look like a frame start
      if (p == `RX_START_PAIR) p = 2'b00;
      drive_pair(r.lane, p);
    end
    for (int i = `PAIRS_PER_FRAME - 1; i >= 0; i--) begin
      drive_pair(r.lane, r.sample[2*i +: 2]);
    end
    @(negedge glob_clock);
    pair_09      = '0;
    pair_24      = '0;
    frame_sample = r.sample;
    frame_sel    = (r.lane == r.sel);
    frame_stb    = 1'b1;
    @(negedge glob_clock);
    frame_stb = 1'b0;
    if (r.drain) drain_host();
    repeat (3) @(negedge glob_clock);
    row_idx   = idx;
    row_drain = r.drain;
    row_stb   = 1'b1;
    @(negedge glob_clock);
    row_stb = 1'b0;
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    rst_b        = 1'b0;
    pair_09      = '0;
    pair_24      = '0;
    smi_a3       = 1'b0;
    smi_soe_se   = 1'b0;
    frame_stb    = 1'b0;
    frame_sel    = 1'b0;
    frame_sample = '0;
    row_stb      = 1'b0;
    row_idx      = 0;
    row_drain    = 1'b0;
    report       = 1'b0;
    lfsr         = 16'd42;
    build_table();
    cycle_limit = 200;
    foreach (rows_q[k]) begin
      cycle_limit += rows_q[k].fill + `PAIRS_PER_FRAME + 4 * 6;
    end
    repeat (2) @(negedge glob_clock);
    rst_b = 1'b1;
    foreach (rows_q[k]) begin
      run_row(k, rows_q[k]);
    end
    @(negedge glob_clock);
    report = 1'b1;
    @(negedge glob_clock);
    report = 1'b0;
    repeat (2) @(negedge glob_clock);
    if (err_cnt == 0 && i_dut.u_props.fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tb_rx_checker.sv
`timescale 1ns/100ps
`include "cariboulite_defs.svh"

module tb_rx_checker
  import iq_types_pkg::*, smi_types_pkg::*;
(
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  input  logic       i_smi_soe_se,
  input  smi_byte_t  i_smi_data,
  input  logic       i_smi_read_req,
  input  logic       i_rx_overflow,
  input  logic       i_frame_stb,
  input  logic       i_frame_sel,
  input  iq_sample_t i_frame_sample,
  input  logic       i_row_stb,
  input  int         i_row_idx,
  input  logic       i_row_drain,
  input  logic       i_report,
  output int         o_err_cnt
);

  // 16 FIFO slots plus the word parked in the read engine
  localparam int CAPACITY = (1 << `RX_FIFO_AW) + 1;

  iq_sample_t model_q[$];
  iq_sample_t head;
  smi_byte_t  exp_byte;
  logic       exp_req;
  logic       model_ovf = 1'b0;
  logic       soe_q = 1'b0;
  logic       rst_q = 1'b0;
  int         byte_pos = 0;
  int         row_errs = 0;
  int         err_total = 0;
  int         tests = 0;
  int         bytes_seen = 0;

  assign o_err_cnt = err_total;

  task automatic count_error();
    row_errs++;
    err_total++;
  endtask

  // One result line per finished test
  task automatic print_result(input string name);
    if (row_errs == 0) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: fail, %0d errors", name, row_errs);
    end
    row_errs = 0;
    tests++;
  endtask

  // ==========================================================================
  // Model and compare on the rising edge
  // ==========================================================================
  always @(posedge i_glob_clock) begin
    soe_q <= i_smi_soe_se;
    rst_q <= i_rst_b;
    // First cycle after release still shows reset values
    if (i_rst_b && !rst_q) begin
      if (i_smi_read_req !== 1'b0) begin
        $display("ERR o_smi_read_req exp 0 got %h", i_smi_read_req);
        count_error();
      end
      if (i_rx_overflow !== 1'b0) begin
        $display("ERR o_rx_overflow exp 0 got %h", i_rx_overflow);
        count_error();
      end
      print_result("Reset");
    end
    // Frame done on the selected lane is kept only if there is room
    if (i_frame_stb && i_frame_sel) begin
      if (model_q.size() < CAPACITY) begin
        model_q.push_back(i_frame_sample);
      end else begin
        model_ovf = 1'b1;
      end
    end
    // Host takes bytes MSB first on each soe rise
    if (i_smi_soe_se && !soe_q) begin
      bytes_seen++;
      if (model_q.size() == 0) begin
        $display("Host strobed a byte while no sample was expected");
        count_error();
      end else begin
        head     = model_q[0];
        exp_byte = head[`SAMPLE_W-1-8*byte_pos -: 8];
        if (i_smi_data !== exp_byte) begin
          $display("ERR o_smi_data exp %02h got %02h", exp_byte, i_smi_data);
          count_error();
        end
        byte_pos++;
        if (byte_pos == `SMI_BYTES) begin
          void'(model_q.pop_front());
          byte_pos = 0;
        end
      end
    end
    if (i_row_stb) begin
      if (i_rx_overflow !== model_ovf) begin
        $display("ERR o_rx_overflow exp %h got %h", model_ovf, i_rx_overflow);
        count_error();
      end
      // Drained row leaves nothing behind
      if (i_row_drain && model_q.size() != 0) begin
        $display("Host drain ended with %0d samples still expected", model_q.size());
        count_error();
      end
      // Request stays up while a sample still waits for the host
      exp_req = (model_q.size() != 0);
      if (i_smi_read_req !== exp_req) begin
        $display("ERR o_smi_read_req exp %h got %h", exp_req, i_smi_read_req);
        count_error();
      end
      print_result($sformatf("Row %0d", i_row_idx));
    end
    if (i_report) begin
      $display("Tests %0d, bytes %0d, errors %0d", tests, bytes_seen, err_total);
    end
  end

endmodule

//--- tb_rx_props.sv
`timescale 1ns/100ps

module tb_rx_props
  import smi_types_pkg::*;
(
  input logic      i_glob_clock,
  input logic      i_rst_b,
  input logic      i_smi_soe_se,
  input smi_byte_t i_smi_data,
  input logic      i_smi_read_req,
  input logic      i_rx_overflow
);

  // Failed assertions so far, read by the testbench top
  int fail_cnt = 0;

  // ==========================================================================
  // Host bus and drop flag rules
  // ==========================================================================
  // Drop flag is sticky until reset
  a_ovf_sticky: assert property (@(posedge i_glob_clock)
    (i_rst_b && i_rx_overflow) |=> i_rx_overflow)
    else begin
      fail_cnt++;
      $error("o_rx_overflow fell while reset was inactive");
    end

  // Byte held until the host strobes
  a_data_stable: assert property (@(posedge i_glob_clock) disable iff (!i_rst_b)
    (i_smi_read_req && !i_smi_soe_se) |=> $stable(i_smi_data))
    else begin
      fail_cnt++;
      $error("o_smi_data changed with no soe strobe");
    end

  // Nothing to read right out of reset
  a_req_after_reset: assert property (@(posedge i_glob_clock)
    $rose(i_rst_b) |-> !i_smi_read_req)
    else begin
      fail_cnt++;
      $error("o_smi_read_req high in the first cycle after reset");
    end

endmodule

//--- rx_modem_top.sv
`timescale 1ns/100ps

module rx_modem_top
  import iq_types_pkg::*, smi_types_pkg::*;
(
  input  logic      i_glob_clock,
  input  logic      i_rst_b,
  input  ddr_pair_t i_iq_rx_09_pair,
  input  ddr_pair_t i_iq_rx_24_pair,
  input  logic      i_smi_a3,
  input  logic      i_smi_soe_se,
  output smi_byte_t o_smi_data,
  output logic      o_smi_read_req,
  output logic      o_rx_overflow
);

  // ========================================================================
  // Inner signals
  // ========================================================================
  logic       push_09;
  logic       push_24;
  logic       ovf_09;
  logic       ovf_24;
  iq_sample_t sample_09;
  iq_sample_t sample_24;

  logic       fifo_push;
  logic       fifo_pull;
  logic       fifo_full;
  logic       fifo_empty;
  iq_sample_t fifo_wdata;
  iq_sample_t fifo_rdata;
  logic       lane_ovf;

  // ========================================================================
  // Lanes
  // ========================================================================
  // 900 MHz lane, straight polarity
  lvds_rx #(
    .INVERT(0)
  ) u_rx_09 (
    .i_glob_clock(i_glob_clock),
    .i_rst_b     (i_rst_b),
    .i_pair      (i_iq_rx_09_pair),
    .i_fifo_full (fifo_full),
    .o_push      (push_09),
    .o_sample    (sample_09),
    .o_overflow  (ovf_09)
  );

  // 2.4 GHz lane comes in on the N pin
  lvds_rx #(
    .INVERT(1)
  ) u_rx_24 (
    .i_glob_clock(i_glob_clock),
    .i_rst_b     (i_rst_b),
    .i_pair      (i_iq_rx_24_pair),
    .i_fifo_full (fifo_full),
    .o_push      (push_24),
    .o_sample    (sample_24),
    .o_overflow  (ovf_24)
  );

  // SA3 low picks 09, high picks 24
  assign fifo_push  = i_smi_a3 ? push_24 : push_09;
  assign fifo_wdata = i_smi_a3 ? sample_24 : sample_09;
  assign lane_ovf   = i_smi_a3 ? ovf_24 : ovf_09;

  // Sticky drop flag, cleared only by reset
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      o_rx_overflow <= 1'b0;
    end else if (lane_ovf) begin
      o_rx_overflow <= 1'b1;
    end
  end

  // ========================================================================
  // FIFO and host side
  // ========================================================================
  sample_fifo u_rx_fifo (
    .i_glob_clock(i_glob_clock),
    .i_rst_b     (i_rst_b),
    .i_push      (fifo_push),
    .i_data      (fifo_wdata),
    .i_pull      (fifo_pull),
    .o_data      (fifo_rdata),
    .o_full      (fifo_full),
    .o_empty     (fifo_empty)
  );

  smi_rx_reader u_smi_reader (
    .i_glob_clock  (i_glob_clock),
    .i_rst_b       (i_rst_b),
    .i_fifo_empty  (fifo_empty),
    .i_fifo_data   (fifo_rdata),
    .o_fifo_pull   (fifo_pull),
    .i_smi_soe_se  (i_smi_soe_se),
    .o_smi_data    (o_smi_data),
    .o_smi_read_req(o_smi_read_req)
  );

endmodule

//--- smi_rx_reader.sv
`timescale 1ns/100ps
`include "cariboulite_defs.svh"

module smi_rx_reader
  import iq_types_pkg::*, smi_types_pkg::*;
(
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  input  logic       i_fifo_empty,
  input  iq_sample_t i_fifo_data,
  output logic       o_fifo_pull,
  input  logic       i_smi_soe_se,
  output smi_byte_t  o_smi_data,
  output logic       o_smi_read_req
);

  localparam byte_idx_t LAST_BYTE = byte_idx_t'(`SMI_BYTES - 1);

  smi_state_t state;
  byte_idx_t  byte_idx;
  iq_sample_t sample_r;
  logic       soe_d;
  logic       soe_rise;

  // ========================================================================
  // Host strobe edge
  // ========================================================================
  // Host latches the byte, then raises soe
  assign soe_rise = i_smi_soe_se & ~soe_d;

  // Pull straight from idle so the word lands in FETCH
  assign o_fifo_pull = (state == SMI_IDLE) && !i_fifo_empty;

  // ========================================================================
  // Read FSM
  // ========================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      state          <= SMI_IDLE;
      byte_idx       <= '0;
      soe_d          <= 1'b0;
      o_smi_data     <= '0;
      o_smi_read_req <= 1'b0;
    end else begin
      soe_d <= i_smi_soe_se;
      case (state)
        SMI_IDLE: begin
          if (!i_fifo_empty) begin
            state <= SMI_FETCH;
          end
        end
        SMI_FETCH: begin
          // FIFO word valid now, top byte goes out first
          byte_idx       <= '0;
          o_smi_data     <= i_fifo_data[`SAMPLE_W-1 -: 8];
          o_smi_read_req <= 1'b1;
          state          <= SMI_SERVE;
        end
        SMI_SERVE: begin
          if (soe_rise) begin
            if (byte_idx == LAST_BYTE) begin
              // Sample used up, go look for the next one
              o_smi_read_req <= 1'b0;
              state          <= SMI_IDLE;
            end else begin
              byte_idx   <= byte_idx + 1'b1;
              o_smi_data <= sample_r[`SAMPLE_W-9 -: 8];
            end
          end
        end
        default: state <= SMI_IDLE;
      endcase
    end
  end

  // ========================================================================
  // Byte shifter
  // ========================================================================
  // Next byte always sits just below the top
  always_ff @(posedge i_glob_clock) begin
    if (state == SMI_FETCH) begin
      sample_r <= i_fifo_data;
    end else if (state == SMI_SERVE && soe_rise) begin
      sample_r <= {sample_r[`SAMPLE_W-9:0], 8'h00};
    end
  end

endmodule

//--- sample_fifo.sv
`timescale 1ns/100ps
`include "cariboulite_defs.svh"

module sample_fifo
  import iq_types_pkg::*;
(
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  input  logic       i_push,
  input  iq_sample_t i_data,
  input  logic       i_pull,
  output iq_sample_t o_data,
  output logic       o_full,
  output logic       o_empty
);

  localparam int DEPTH = 1 << `RX_FIFO_AW;

  iq_sample_t mem [DEPTH];
  fifo_addr_t wr_ptr;
  fifo_addr_t rd_ptr;
  // Extra lap bit tells full from empty
  logic       wr_wrap;
  logic       rd_wrap;
  logic       do_push;

  // ========================================================================
  // Flags
  // ========================================================================
  // Same slot, different lap
  assign o_full  = (wr_ptr == rd_ptr) && (wr_wrap != rd_wrap);
  // Same slot, same lap
  assign o_empty = (wr_ptr == rd_ptr) && (wr_wrap == rd_wrap);

  // Push on a full FIFO is dropped here
  assign do_push = i_push & ~o_full;

  // ========================================================================
  // Pointers
  // ========================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      wr_ptr  <= '0;
      wr_wrap <= 1'b0;
      rd_ptr  <= '0;
      rd_wrap <= 1'b0;
    end else begin
      if (do_push) begin
        {wr_wrap, wr_ptr} <= {wr_wrap, wr_ptr} + 1'b1;
      end
      // Reader checks empty before it pulls
      if (i_pull) begin
        {rd_wrap, rd_ptr} <= {rd_wrap, rd_ptr} + 1'b1;
      end
    end
  end

  // ========================================================================
  // Storage
  // ========================================================================
  // Registered read, word valid the cycle after pull
  always_ff @(posedge i_glob_clock) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
    if (i_pull) begin
      o_data <= mem[rd_ptr];
    end
  end

endmodule

//--- lvds_rx.sv
`timescale 1ns/100ps
`include "cariboulite_defs.svh"

module lvds_rx
  import iq_types_pkg::*;
#(
  parameter int INVERT = 0
) (
  input  logic       i_glob_clock,
  input  logic       i_rst_b,
  input  ddr_pair_t  i_pair,
  input  logic       i_fifo_full,
  output logic       o_push,
  output iq_sample_t o_sample,
  output logic       o_overflow
);

  localparam int CNT_W = $clog2(`PAIRS_PER_FRAME);
  localparam logic [CNT_W-1:0] LAST_PAIR = CNT_W'(`PAIRS_PER_FRAME - 1);

  // ========================================================================
  // Pair conditioning
  // ========================================================================
  ddr_pair_t                pair_in;
  rx_state_t                state;
  logic [CNT_W-1:0]         pair_cnt;
  logic [`SAMPLE_W-3:0]     shift_r;
  logic                     frame_end;

  // N-side pin on the board, so bits come in flipped
  assign pair_in = (INVERT != 0) ? ~i_pair : i_pair;

  // Last pair of the frame is on the pins right now
  assign frame_end = (state == RX_COLLECT) && (pair_cnt == LAST_PAIR);

  // ========================================================================
  // Frame FSM
  // ========================================================================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      state      <= RX_HUNT;
      pair_cnt   <= '0;
      o_push     <= 1'b0;
      o_overflow <= 1'b0;
    end else begin
      // Strobes last one cycle
      o_push     <= 1'b0;
      o_overflow <= 1'b0;
      case (state)
        RX_HUNT: begin
          // Marker counts as pair 1 of the frame
          if (pair_in == `RX_START_PAIR) begin
            state    <= RX_COLLECT;
            pair_cnt <= CNT_W'(1);
          end
        end
        RX_COLLECT: begin
          pair_cnt <= pair_cnt + 1'b1;
          if (frame_end) begin
            // Back to hunting at once, next marker may follow directly
            state      <= RX_HUNT;
            o_push     <= ~i_fifo_full;
            // Whole frame lost when no room
            o_overflow <= i_fifo_full;
          end
        end
        default: state <= RX_HUNT;
      endcase
    end
  end

  // ========================================================================
  // Data path
  // ========================================================================
  // Free-running shifter, MSB pair first
  // Stale pairs fall off the top before the frame completes
  always_ff @(posedge i_glob_clock) begin
    shift_r <= {shift_r[`SAMPLE_W-5:0], pair_in};
  end

  // Capture the full word together with the last pair
  always_ff @(posedge i_glob_clock) begin
    if (frame_end) begin
      o_sample <= {shift_r, pair_in};
    end
  end

endmodule

//--- smi_types_pkg.sv
`include "cariboulite_defs.svh"

package smi_types_pkg;

  // One byte on the SMI data lines
  typedef logic [7:0] smi_byte_t;

  // Position of the byte inside the current sample
  typedef logic [$clog2(`SMI_BYTES)-1:0] byte_idx_t;

  // Read engine
  typedef enum logic [1:0] {
    SMI_IDLE,
    SMI_FETCH,
    SMI_SERVE
  } smi_state_t;

endpackage

//--- iq_types_pkg.sv
`include "cariboulite_defs.svh"

package iq_types_pkg;

  // Full I/Q word as it sits in the FIFO
  typedef logic [`SAMPLE_W-1:0] iq_sample_t;

  // Captured DDR bits, [1] is 0 deg and [0] is 180 deg
  typedef logic [1:0] ddr_pair_t;

  // FIFO read and write pointer, wrap bit kept apart
  typedef logic [`RX_FIFO_AW-1:0] fifo_addr_t;

  // Frame deserializer
  typedef enum logic {
    RX_HUNT,
    RX_COLLECT
  } rx_state_t;

endpackage

//--- cariboulite_defs.svh
`ifndef CARIBOULITE_DEFS_SVH
`define CARIBOULITE_DEFS_SVH

// ==========================================================================
// Sample path sizes
// ==========================================================================
// One I/Q sample, 16 bits I plus 16 bits Q
`define SAMPLE_W 32
// DDR pairs needed to assemble one sample
`define PAIRS_PER_FRAME 16
// First pair of every frame, 0-deg bit high
`define RX_START_PAIR 2'b10

// Small FIFO so that back-pressure shows quickly
`define RX_FIFO_AW 4

// ==========================================================================
// Host bus
// ==========================================================================
// Byte-wide SMI, MSB first
`define SMI_BYTES 4

`endif
